// File: hw/leaf_consts.svh
`ifndef LEAF_CONSTS_SVH
`define LEAF_CONSTS_SVH

// Network packet layout, most significant field first.
`define PACKET_BITS 49
`define PAYLOAD_BITS 32
`define LEAF_BITS 5
`define PORT_BITS 4
`define TAG_BITS (`PACKET_BITS - `PAYLOAD_BITS - `LEAF_BITS - `PORT_BITS - 1)

// Stream counts on the kernel side.
`define NUM_IN_PORTS 6
`define NUM_OUT_PORTS 3

// Entries per port FIFO, kept a power of two so the pointers wrap on their own.
`define FIFO_DEPTH 8

// Address of this leaf in the fat tree.
`define SELF_LEAF 5'd5

`endif

// File: hw/leaf_pkg.sv
`include "leaf_consts.svh"

package leaf_pkg;

    // One data word as seen by the user kernel.
    typedef logic [`PAYLOAD_BITS-1:0] user_word_t;

    // Network packet. A cycle carries a packet only when vld is set.
    // The tag field carries the source output stream of the sending leaf.
    typedef struct packed {
        logic                  vld;
        logic [`LEAF_BITS-1:0] dest_leaf;
        logic [`PORT_BITS-1:0] dest_port;
        logic [`TAG_BITS-1:0]  tag;
        user_word_t            payload;
    } bft_packet_t;

    // Destination of one output stream, written by configuration packets.
    typedef struct packed {
        logic [`LEAF_BITS-1:0] dest_leaf;
        logic [`PORT_BITS-1:0] dest_port;
    } route_cfg_t;

endpackage

// File: hw/port_fifo.sv
`timescale 1ns/1ns
`include "leaf_consts.svh"

module port_fifo import leaf_pkg::*; #(
    parameter type entry_t = user_word_t
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  entry_t push_data,
    output logic   full,
    input  logic   pop,
    output entry_t pop_data,
    output logic   empty
);

    localparam int PTR_BITS = $clog2(`FIFO_DEPTH);

    entry_t              mem [`FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign full     = (count == `FIFO_DEPTH);
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;

    // The head is visible in the same cycle it becomes valid.
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/leaf_rx_demux.sv
`timescale 1ns/1ns
`include "leaf_consts.svh"

module leaf_rx_demux import leaf_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  bft_packet_t               pkt_in,
    input  logic [`NUM_IN_PORTS-1:0]  in_full,
    output logic [`NUM_IN_PORTS-1:0]  in_push,
    output user_word_t                in_word,
    output logic [`NUM_OUT_PORTS-1:0] cfg_we,
    output route_cfg_t                cfg_data
);

    logic                      for_us;
    logic [`NUM_IN_PORTS-1:0]  port_hit;
    logic [`NUM_OUT_PORTS-1:0] cfg_hit;
    logic [`NUM_IN_PORTS-1:0]  push_q;

    assign for_us = pkt_in.vld && (pkt_in.dest_leaf == `SELF_LEAF);

    // Port 0 is configuration, ports 1 to 6 feed the kernel, the rest fall through.
    always_comb begin
        for (int i = 0; i < `NUM_IN_PORTS; i++) begin
            port_hit[i] = for_us && (pkt_in.dest_port == `PORT_BITS'(i + 1));
        end
        for (int s = 0; s < `NUM_OUT_PORTS; s++) begin
            cfg_hit[s] = for_us && (pkt_in.dest_port == '0) &&
                         (pkt_in.payload[1:0] == 2'(s + 1));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            push_q <= '0;
            cfg_we <= '0;
        end else begin
            push_q <= port_hit;
            cfg_we <= cfg_hit;
        end
    end

    always_ff @(posedge clk) begin
        in_word            <= pkt_in.payload;
        cfg_data.dest_leaf <= pkt_in.payload[8:4];
        cfg_data.dest_port <= pkt_in.payload[12:9];
    end

    // A word whose FIFO is full at write time is dropped.
    assign in_push = push_q & ~in_full;

endmodule

// File: hw/leaf_tx_arbiter.sv
`timescale 1ns/1ns
`include "leaf_consts.svh"

module leaf_tx_arbiter import leaf_pkg::*; (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  resend,
    input  logic [`NUM_OUT_PORTS-1:0]             out_empty,
    input  user_word_t [`NUM_OUT_PORTS-1:0]       out_head,
    input  route_cfg_t [`NUM_OUT_PORTS-1:0]       route,
    output logic [`NUM_OUT_PORTS-1:0]             out_pop,
    output bft_packet_t                           pkt_out
);

    localparam int SEL_BITS = $clog2(`NUM_OUT_PORTS);

    logic [SEL_BITS-1:0] last_q;
    logic [SEL_BITS-1:0] grant_idx;
    logic                grant_any;

    // Search starts at the stream after the one served last.
    always_comb begin : rr_search
        logic [SEL_BITS-1:0] cand;
        grant_any = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= `NUM_OUT_PORTS; k++) begin
            cand = SEL_BITS'((int'(last_q) + k) % `NUM_OUT_PORTS);
            if (!resend && !grant_any && !out_empty[cand]) begin
                grant_any = 1'b1;
                grant_idx = cand;
            end
        end
    end

    always_comb begin
        out_pop = '0;
        if (grant_any) begin
            out_pop[grant_idx] = 1'b1;
        end
    end

    // During resend the last packet is held, so the one masked at the port
    // is shown again once resend drops.
    always_ff @(posedge clk) begin
        if (reset) begin
            last_q  <= SEL_BITS'(`NUM_OUT_PORTS - 1);
            pkt_out <= '0;
        end else if (!resend) begin
            if (grant_any) begin
                last_q            <= grant_idx;
                pkt_out.vld       <= 1'b1;
                pkt_out.dest_leaf <= route[grant_idx].dest_leaf;
                pkt_out.dest_port <= route[grant_idx].dest_port;
                pkt_out.tag       <= `TAG_BITS'(grant_idx) + 1'b1;
                pkt_out.payload   <= out_head[grant_idx];
            end else begin
                pkt_out <= '0;
            end
        end
    end

endmodule

// File: hw/user_kernel.sv
`timescale 1ns/1ns
`include "leaf_consts.svh"

module user_kernel import leaf_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  user_word_t [`NUM_IN_PORTS-1:0]   din,
    input  logic [`NUM_IN_PORTS-1:0]         din_vld,
    output logic [`NUM_IN_PORTS-1:0]         din_ack,
    output user_word_t [`NUM_OUT_PORTS-1:0]  dout,
    output logic [`NUM_OUT_PORTS-1:0]        dout_vld,
    input  logic [`NUM_OUT_PORTS-1:0]        dout_ack
);

    // Output s joins inputs 2s and 2s+1.
    for (genvar s = 0; s < `NUM_OUT_PORTS; s++) begin : g_stream
        user_word_t a;
        user_word_t b;
        user_word_t result;
        user_word_t res_q;
        logic       vld_q;
        logic       fire;

        assign a = din[2*s];
        assign b = din[2*s+1];

        if (s == 0) begin : g_add
            assign result = a + b;
        end else if (s == 1) begin : g_xor
            assign result = a ^ b;
        end else begin : g_max
            assign result = (a > b) ? a : b;
        end

        // The result register frees up in the cycle its word is taken.
        assign fire = din_vld[2*s] && din_vld[2*s+1] && (!vld_q || dout_ack[s]);

        assign din_ack[2*s]   = fire;
        assign din_ack[2*s+1] = fire;

        always_ff @(posedge clk) begin
            if (reset) begin
                vld_q <= 1'b0;
            end else if (fire) begin
                vld_q <= 1'b1;
            end else if (dout_ack[s]) begin
                vld_q <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (fire) begin
                res_q <= result;
            end
        end

        assign dout[s]     = res_q;
        assign dout_vld[s] = vld_q;
    end

endmodule

// File: hw/leaf_interface.sv
`timescale 1ns/1ns
`include "leaf_consts.svh"

module leaf_interface import leaf_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             resend,
    input  bft_packet_t                      din_leaf_bft2interface,
    output bft_packet_t                      dout_leaf_interface2bft,
    output user_word_t [`NUM_IN_PORTS-1:0]   dout_leaf_interface2user,
    output logic [`NUM_IN_PORTS-1:0]         vld_interface2user,
    input  logic [`NUM_IN_PORTS-1:0]         ack_user2interface,
    input  user_word_t [`NUM_OUT_PORTS-1:0]  din_leaf_user2interface,
    input  logic [`NUM_OUT_PORTS-1:0]        vld_user2interface,
    output logic [`NUM_OUT_PORTS-1:0]        ack_interface2user
);

    logic [`NUM_IN_PORTS-1:0]         in_full;
    logic [`NUM_IN_PORTS-1:0]         in_push;
    logic [`NUM_IN_PORTS-1:0]         in_empty;
    user_word_t                       in_word;
    logic [`NUM_OUT_PORTS-1:0]        cfg_we;
    route_cfg_t                       cfg_data;
    route_cfg_t [`NUM_OUT_PORTS-1:0]  route_q;
    logic [`NUM_OUT_PORTS-1:0]        out_full;
    logic [`NUM_OUT_PORTS-1:0]        out_empty;
    logic [`NUM_OUT_PORTS-1:0]        out_pop;
    user_word_t [`NUM_OUT_PORTS-1:0]  out_head;

    leaf_rx_demux u_rx_demux (
        .clk      (clk),
        .reset    (reset),
        .pkt_in   (din_leaf_bft2interface),
        .in_full  (in_full),
        .in_push  (in_push),
        .in_word  (in_word),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data)
    );

    for (genvar i = 0; i < `NUM_IN_PORTS; i++) begin : g_in_fifo
        port_fifo #(.entry_t(user_word_t)) u_fifo (
            .clk       (clk),
            .reset     (reset),
            .push      (in_push[i]),
            .push_data (in_word),
            .full      (in_full[i]),
            .pop       (vld_interface2user[i] && ack_user2interface[i]),
            .pop_data  (dout_leaf_interface2user[i]),
            .empty     (in_empty[i])
        );
        assign vld_interface2user[i] = !in_empty[i];
    end

    // Kernel results wait here until the arbiter sends them out.
    for (genvar j = 0; j < `NUM_OUT_PORTS; j++) begin : g_out_fifo
        port_fifo #(.entry_t(user_word_t)) u_fifo (
            .clk       (clk),
            .reset     (reset),
            .push      (vld_user2interface[j] && ack_interface2user[j]),
            .push_data (din_leaf_user2interface[j]),
            .full      (out_full[j]),
            .pop       (out_pop[j]),
            .pop_data  (out_head[j]),
            .empty     (out_empty[j])
        );
        assign ack_interface2user[j] = !out_full[j];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            route_q <= '0;
        end else begin
            for (int s = 0; s < `NUM_OUT_PORTS; s++) begin
                if (cfg_we[s]) begin
                    route_q[s] <= cfg_data;
                end
            end
        end
    end

    leaf_tx_arbiter u_tx_arbiter (
        .clk       (clk),
        .reset     (reset),
        .resend    (resend),
        .out_empty (out_empty),
        .out_head  (out_head),
        .route     (route_q),
        .out_pop   (out_pop),
        .pkt_out   (dout_leaf_interface2bft)
    );

endmodule

// File: hw/leaf_i6o3.sv
`timescale 1ns/1ns
`include "leaf_consts.svh"

module leaf_i6o3 import leaf_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        resend,
    input  bft_packet_t din_leaf_bft2interface,
    output bft_packet_t dout_leaf_interface2bft
);

    user_word_t [`NUM_IN_PORTS-1:0]  word_to_user;
    logic [`NUM_IN_PORTS-1:0]        vld_to_user;
    logic [`NUM_IN_PORTS-1:0]        ack_from_user;
    user_word_t [`NUM_OUT_PORTS-1:0] word_from_user;
    logic [`NUM_OUT_PORTS-1:0]       vld_from_user;
    logic [`NUM_OUT_PORTS-1:0]       ack_to_user;
    bft_packet_t                     pkt_int;

    leaf_interface u_leaf_interface (
        .clk                      (clk),
        .reset                    (reset),
        .resend                   (resend),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (pkt_int),
        .dout_leaf_interface2user (word_to_user),
        .vld_interface2user       (vld_to_user),
        .ack_user2interface       (ack_from_user),
        .din_leaf_user2interface  (word_from_user),
        .vld_user2interface       (vld_from_user),
        .ack_interface2user       (ack_to_user)
    );

    user_kernel u_user_kernel (
        .clk      (clk),
        .reset    (reset),
        .din      (word_to_user),
        .din_vld  (vld_to_user),
        .din_ack  (ack_from_user),
        .dout     (word_from_user),
        .dout_vld (vld_from_user),
        .dout_ack (ack_to_user)
    );

    // The network ignores the port while it asks for a resend.
    assign dout_leaf_interface2bft = resend ? '0 : pkt_int;

endmodule

// File: tb/leaf_i6o3_checker.sv
`timescale 1ns/1ns

module leaf_i6o3_checker import leaf_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        resend,
    input bft_packet_t dout_leaf_interface2bft
);

    property zero_during_resend;
        @(posedge clk) disable iff (reset)
            resend |-> (dout_leaf_interface2bft == '0);
    endproperty

    // The first two cycles out of reset carry no packet.
    property zero_after_reset;
        @(posedge clk) $fell(reset) |->
            (dout_leaf_interface2bft == '0) ##1 (dout_leaf_interface2bft == '0);
    endproperty

    property tag_in_range;
        @(posedge clk) disable iff (reset)
            dout_leaf_interface2bft.vld |->
                (dout_leaf_interface2bft.tag inside {[1:3]});
    endproperty

    assert property (zero_during_resend)
        else $error("Packet output was not zero while resend was high.");
    assert property (zero_after_reset)
        else $error("Packet output was not zero in the two cycles after reset.");
    assert property (tag_in_range)
        else $error("Outgoing packet carried a tag outside streams 1 to 3.");

endmodule

bind leaf_i6o3 leaf_i6o3_checker u_checker (
    .clk                     (clk),
    .reset                   (reset),
    .resend                  (resend),
    .dout_leaf_interface2bft (dout_leaf_interface2bft)
);

// File: tb/tb_leaf_i6o3.sv
`timescale 1ns/1ns
`include "leaf_consts.svh"

module tb_leaf_i6o3 import leaf_pkg::*; ();

    localparam logic [31:0] SEED = 32'h7a5b_9f2b;
    localparam int WAIT_LIMIT  = 3000;
    localparam int MAX_PENDING = 6;

    logic        clk;
    logic        reset;
    logic        resend;
    logic        resend_en;
    bft_packet_t din;
    bft_packet_t dout;

    user_word_t in_q [`NUM_IN_PORTS][$];
    user_word_t exp_q [`NUM_OUT_PORTS][$];
    route_cfg_t cfg_model [`NUM_OUT_PORTS];
    string      test_name;
    int         checks;
    int         value_errors;
    int         other_errors;

    leaf_i6o3 u_dut (
        .clk                     (clk),
        .reset                   (reset),
        .resend                  (resend),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout)
    );

    always #4 clk = ~clk;

    function automatic user_word_t kernel_result(input int s, input user_word_t a,
                                                 input user_word_t b);
        case (s)
            0:       return a + b;
            1:       return a ^ b;
            default: return (a > b) ? a : b;
        endcase
    endfunction

    // Random stall pulses from the network side come with every driven cycle.
    task automatic drive(input bft_packet_t pkt);
        @(posedge clk);
        din    <= pkt;
        resend <= resend_en && ($urandom_range(99) < 20);
    endtask

    task automatic send_word(input int port, input user_word_t word);
        bft_packet_t pkt;
        int          s;
        pkt           = '0;
        pkt.vld       = 1'b1;
        pkt.dest_leaf = `SELF_LEAF;
        pkt.dest_port = 4'(port);
        pkt.payload   = word;
        drive(pkt);
        in_q[port-1].push_back(word);
        s = (port - 1) / 2;
        if (in_q[2*s].size() > 0 && in_q[2*s+1].size() > 0) begin
            exp_q[s].push_back(kernel_result(s, in_q[2*s].pop_front(),
                                             in_q[2*s+1].pop_front()));
        end
    endtask

    // Payload bits 1..0 pick the stream, 8..4 the leaf and 12..9 the port.
    task automatic send_cfg(input int sel, input logic [4:0] leaf, input logic [3:0] port);
        bft_packet_t pkt;
        pkt                = '0;
        pkt.vld            = 1'b1;
        pkt.dest_leaf      = `SELF_LEAF;
        pkt.payload        = $urandom;
        pkt.payload[1:0]   = 2'(sel);
        pkt.payload[8:4]   = leaf;
        pkt.payload[12:9]  = port;
        drive(pkt);
        if (sel != 0) begin
            cfg_model[sel-1].dest_leaf = leaf;
            cfg_model[sel-1].dest_port = port;
        end
    endtask

    // A packet for another leaf, or for a port this leaf does not have.
    task automatic send_stray();
        bft_packet_t pkt;
        pkt.vld     = 1'b1;
        pkt.tag     = 7'($urandom);
        pkt.payload = $urandom;
        if ($urandom_range(1) == 1) begin
            pkt.dest_leaf = 5'($urandom_range(31));
            if (pkt.dest_leaf == `SELF_LEAF) begin
                pkt.dest_leaf = pkt.dest_leaf + 1'b1;
            end
            pkt.dest_port = 4'($urandom_range(6));
        end else begin
            pkt.dest_leaf = `SELF_LEAF;
            pkt.dest_port = 4'($urandom_range(15, 7));
        end
        drive(pkt);
    endtask

    task automatic wait_room(input int s);
        int n;
        n = 0;
        while (exp_q[s].size() >= MAX_PENDING && n < WAIT_LIMIT) begin
            drive('0);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            other_errors++;
            $display("%s: stream %0d did not make room before the timeout", test_name, s + 1);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size()) > 0 && n < WAIT_LIMIT) begin
            drive('0);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            other_errors++;
            $display("%s: results still missing after the timeout", test_name);
        end
        // A few quiet cycles catch any extra packet.
        repeat (20) drive('0);
    endtask

    task automatic run_traffic(input int pairs, input int stray_pct);
        int s;
        for (int i = 0; i < pairs; i++) begin
            s = $urandom_range(2);
            wait_room(s);
            send_word(2*s + 1, $urandom);
            if ($urandom_range(99) < stray_pct) begin
                send_stray();
            end
            send_word(2*s + 2, $urandom);
            repeat ($urandom_range(2)) drive('0);
        end
    endtask

    task automatic check_value(input string what, input int s, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            value_errors++;
            $display("FAIL %s: stream %0d %s expected %h actual %h",
                     test_name, s + 1, what, expected, actual);
        end
    endtask

    always @(negedge clk) begin : monitor
        user_word_t expected;
        int         s;
        if (!reset) begin
            if (resend) begin
                checks++;
                assert (dout == '0) else begin
                    value_errors++;
                    $display("FAIL %s: output during resend expected 0 actual %h",
                             test_name, dout);
                end
            end else if (dout.vld) begin
                checks++;
                assert (dout.tag inside {[1:3]}) else begin
                    other_errors++;
                    $display("%s: packet tag %0d names no stream", test_name, dout.tag);
                end
                if (dout.tag inside {[1:3]}) begin
                    s = int'(dout.tag) - 1;
                    assert (exp_q[s].size() > 0) else begin
                        other_errors++;
                        $display("%s: stream %0d sent a packet nobody expected", test_name, s + 1);
                    end
                    if (exp_q[s].size() > 0) begin
                        expected = exp_q[s].pop_front();
                        check_value("payload", s, expected, dout.payload);
                        check_value("dest_leaf", s, 32'(cfg_model[s].dest_leaf), 32'(dout.dest_leaf));
                        check_value("dest_port", s, 32'(cfg_model[s].dest_port), 32'(dout.dest_port));
                    end
                end
            end else begin
                assert (dout == '0) else begin
                    value_errors++;
                    $display("FAIL %s: idle output cycle expected 0 actual %h",
                             test_name, dout);
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        reset        = 1'b1;
        resend       = 1'b0;
        resend_en    = 1'b0;
        din          = '0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        for (int s = 0; s < `NUM_OUT_PORTS; s++) begin
            cfg_model[s] = '0;
        end
        test_name = "reset";
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        test_name = "config_and_pairs";
        for (int s = 1; s <= `NUM_OUT_PORTS; s++) begin
            send_cfg(s, 5'($urandom), 4'($urandom));
        end
        send_cfg(0, 5'($urandom), 4'($urandom));
        send_stray();
        run_traffic(60, 25);
        drain();

        test_name = "resend_pulses";
        drive('0);
        resend_en <= 1'b1;
        run_traffic(150, 20);
        drive('0);
        resend_en <= 1'b0;
        drain();

        // New routes, then back-to-back pairs on all three streams.
        test_name = "bursts";
        for (int s = 1; s <= `NUM_OUT_PORTS; s++) begin
            send_cfg(s, 5'($urandom), 4'($urandom));
        end
        repeat (4) drive('0);
        resend_en <= 1'b1;
        for (int i = 0; i < 5; i++) begin
            for (int s = 0; s < `NUM_OUT_PORTS; s++) begin
                send_word(2*s + 1, $urandom);
                send_word(2*s + 2, $urandom);
            end
        end
        drive('0);
        resend_en <= 1'b0;
        drain();

        $display("checks=%0d value_errors=%0d other_errors=%0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/leaf_pkg.sv
hw/port_fifo.sv
hw/leaf_rx_demux.sv
hw/leaf_tx_arbiter.sv
hw/user_kernel.sv
hw/leaf_interface.sv
hw/leaf_i6o3.sv
tb/leaf_i6o3_checker.sv
tb/tb_leaf_i6o3.sv

// File: Bender.yml
package:
  name: leaf_i6o3

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/leaf_pkg.sv
      - hw/port_fifo.sv
      - hw/leaf_rx_demux.sv
      - hw/leaf_tx_arbiter.sv
      - hw/user_kernel.sv
      - hw/leaf_interface.sv
      - hw/leaf_i6o3.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/leaf_i6o3_checker.sv
      - tb/tb_leaf_i6o3.sv
